/* verilog/conv_geom_pkg.sv */
`default_nettype none

package conv_geom_pkg;

   // ******************************
   // feature map geometry
   // ******************************
   localparam int img_side   = 32;               // square map, pixels per row
   localparam int img_pixels = 1024;             // img_side * img_side
   localparam int pix_w      = 10;               // pixel / read address width
   localparam int side_w     = $clog2(img_side); // row or column index width
   localparam int win_side   = 3;                // 3x3 window

   // ******************************
   // loop bounds
   // ******************************
   localparam int num_ch      = 3;   // input channels
   localparam int num_taps    = 9;   // win_side * win_side
   localparam int num_groups  = 16;  // 128 kernels over the engines
   localparam int num_engines = 8;

   localparam int ch_w  = $clog2(num_ch);
   localparam int tap_w = $clog2(num_taps);
   localparam int grp_w = $clog2(num_groups);

   // ******************************
   // data and address widths
   // ******************************
   localparam int data_w     = 16;  // feature word
   localparam int wgt_addr_w = 9;   // 432 weight words per pixel
   localparam int out_addr_w = 14;  // one word per window and group

   // position of the nested loops, channel innermost
   typedef struct packed {
      logic [pix_w-1:0] pixel;  // window centre
      logic [grp_w-1:0] group;  // kernel group
      logic [tap_w-1:0] tap;    // window tap, row major
      logic [ch_w-1:0]  ch;     // input channel
   } loop_pos_t;

endpackage

`default_nettype wire

/* verilog/bank_if_pkg.sv */
`default_nettype none

package bank_if_pkg;

   import conv_geom_pkg::*;

   // ******************************
   // ping-pong banks
   // ******************************
   localparam int num_banks = 2;                   // per side
   localparam int bank_w    = $clog2(num_banks);   // bank select width

   // input feature map banks, enables active low
   typedef struct packed {
      logic [num_banks-1:0] sram_en;  // chip enable per bank
      logic [num_banks-1:0] rd;       // read enable per bank
      logic [pix_w-1:0]     addr;     // shared read address
   } in_bank_ctl_t;

   // output result banks, enables active low
   typedef struct packed {
      logic [num_banks-1:0]  sram_en;
      logic [num_banks-1:0]  wr;       // write strobe per bank
      logic [out_addr_w-1:0] addr;     // shared write address (next_addr)
   } out_bank_ctl_t;

   // weight SRAM, one macro per engine
   typedef struct packed {
      logic [num_engines-1:0] sram_en;
      logic [num_engines-1:0] rd;
      logic [wgt_addr_w-1:0]  addr;
   } wgt_ctl_t;

endpackage

`default_nettype wire

/* verilog/conv_sequencer.sv */
`default_nettype none

module conv_sequencer
   import conv_geom_pkg::*;
   import bank_if_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [num_banks-1:0] pre_sram_full,
   input  logic [num_banks-1:0] next_sram_empty,
   input  logic                 image_done,
   output logic                 step,
   output logic                 window_done,
   output logic                 last_step,
   output logic [bank_w-1:0]    bank_sel,
   output loop_pos_t            pos,
   output logic                 calculate_en,
   output wgt_ctl_t             wgt
);

   typedef enum logic [2:0] {
      st_idle,
      st_ready1,
      st_run1,
      st_ready2,
      st_run2
   } state_t;

   state_t                state, state_nxt;
   logic                  lock;       // set after the last step of an image
   logic                  ready;
   logic                  running;
   logic                  pixel_end;  // last step of the current pixel
   logic [wgt_addr_w-1:0] wgt_cnt;

   // ******************************
   // ping-pong state machine
   // ******************************
   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         state <= st_idle;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle:   if (pre_sram_full[0]) state_nxt = st_ready1;
         st_ready1: state_nxt = st_run1;
         st_run1:   if (image_done) state_nxt = st_ready2;
         st_ready2: state_nxt = st_run2;
         st_run2:   if (image_done) state_nxt = st_ready1;
         default:   state_nxt = st_idle;
      endcase
   end

   assign ready    = (state == st_ready1) || (state == st_ready2);
   assign running  = (state == st_run1) || (state == st_run2);
   assign bank_sel = ((state == st_ready2) || (state == st_run2)) ? bank_w'(1) : bank_w'(0);

   // both stage levels of the active bank must be up
   assign step = running && !lock && pre_sram_full[bank_sel] && next_sram_empty[bank_sel];

   assign window_done = (pos.ch == ch_w'(num_ch - 1)) && (pos.tap == tap_w'(num_taps - 1));
   assign pixel_end   = window_done && (pos.group == grp_w'(num_groups - 1));
   assign last_step   = pixel_end && (pos.pixel == pix_w'(img_pixels - 1));

   // ******************************
   // nested loop counters
   // ******************************
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pos     <= '0;
         lock    <= 1'b0;
         wgt_cnt <= '0;
      end else if (ready) begin
         pos     <= '0;  // fresh image
         lock    <= 1'b0;
         wgt_cnt <= '0;
      end else if (step) begin
         if (pos.ch == ch_w'(num_ch - 1)) begin
            pos.ch <= '0;
            if (pos.tap == tap_w'(num_taps - 1)) begin
               pos.tap <= '0;
               if (pos.group == grp_w'(num_groups - 1)) begin
                  pos.group <= '0;
                  pos.pixel <= pos.pixel + 1'b1;  // wraps after the last pixel
               end else begin
                  pos.group <= pos.group + 1'b1;
               end
            end else begin
               pos.tap <= pos.tap + 1'b1;
            end
         end else begin
            pos.ch <= pos.ch + 1'b1;
         end

         if (last_step)
            lock <= 1'b1;  // hold until the ready state

         // ch + 3*tap + 27*group
         if (pixel_end)
            wgt_cnt <= '0;
         else
            wgt_cnt <= wgt_cnt + 1'b1;
      end
   end

   assign calculate_en = step;

   assign wgt.sram_en = {num_engines{~step}};
   assign wgt.rd      = {num_engines{~step}};
   assign wgt.addr    = wgt_cnt;

endmodule

`default_nettype wire

/* verilog/window_addr_gen.sv */
`default_nettype none

module window_addr_gen
   import conv_geom_pkg::*;
   import bank_if_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              step,
   input  logic [bank_w-1:0] bank_sel,
   input  loop_pos_t         pos,
   input  logic [data_w-1:0] din,
   output in_bank_ctl_t      in_bank,
   output logic [data_w-1:0] dout
);

   logic [side_w-1:0]        row, col;
   logic [1:0]               row_off, col_off;  // 0..2, centred below
   logic signed [side_w+1:0] nb_row, nb_col;
   logic                     pad;
   logic [pix_w-1:0]         nb_addr;
   logic [pix_w-1:0]         addr_q;
   logic                     pad_q;

   // ******************************
   // neighbour position
   // ******************************
   assign row = pos.pixel[pix_w-1:side_w];
   assign col = pos.pixel[side_w-1:0];

   assign row_off = 2'(pos.tap / win_side);
   assign col_off = 2'(pos.tap % win_side);

   assign nb_row = $signed({2'b00, row}) + $signed({{side_w{1'b0}}, row_off}) - 1;
   assign nb_col = $signed({2'b00, col}) + $signed({{side_w{1'b0}}, col_off}) - 1;

   // plain bounds check on both axes
   assign pad = (nb_row < 0) || (nb_row >= img_side) ||
                (nb_col < 0) || (nb_col >= img_side);

   // row * img_side + col, side is a power of two
   assign nb_addr = {nb_row[side_w-1:0], nb_col[side_w-1:0]};

   // ******************************
   // read address and pad pipeline
   // ******************************
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         addr_q <= '0;
         pad_q  <= 1'b0;
      end else if (step) begin
         addr_q <= pad ? '0 : nb_addr;  // padded taps park at zero
         pad_q  <= pad;                 // lines up with din
      end
   end

   always_comb begin
      in_bank.sram_en = '1;
      in_bank.rd      = '1;
      in_bank.sram_en[bank_sel] = ~step;
      in_bank.rd[bank_sel]      = ~step;
   end

   assign in_bank.addr = addr_q;

   // border taps feed zeros to the engines
   assign dout = pad_q ? '0 : din;

endmodule

`default_nettype wire

/* verilog/result_writer.sv */
`default_nettype none

module result_writer
   import conv_geom_pkg::*;
   import bank_if_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   step,
   input  logic                   window_done,
   input  logic                   last_step,
   input  logic [bank_w-1:0]      bank_sel,
   output logic [num_engines-1:0] asm_send,
   output out_bank_ctl_t          out_bank,
   output logic                   image_done
);

   logic                  send_d1, send_d2;  // two step send delay
   logic                  draining;          // flushing after the last step
   logic                  adv;
   logic                  fire;
   logic [bank_w-1:0]     bank_q;
   logic [out_addr_w-1:0] wr_addr;

   // the pipe moves with the steps, and by itself once the image is locked
   assign adv  = step || draining;
   assign fire = adv && send_d2;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         send_d1    <= 1'b0;
         send_d2    <= 1'b0;
         draining   <= 1'b0;
         image_done <= 1'b0;
         bank_q     <= '0;
         wr_addr    <= '0;
      end else begin
         bank_q     <= bank_sel;
         image_done <= fire && draining;  // one cycle after the last write

         if (adv) begin
            send_d1 <= step && window_done;
            send_d2 <= send_d1;
         end

         if (step && last_step)
            draining <= 1'b1;
         else if (fire)
            draining <= 1'b0;

         // ******************************
         // output address
         // ******************************
         if (bank_sel != bank_q)
            wr_addr <= '0;  // new bank pair, new image
         else if (fire)
            wr_addr <= wr_addr + 1'b1;
      end
   end

   assign asm_send = {num_engines{fire}};

   always_comb begin
      out_bank.sram_en = '1;
      out_bank.wr      = '1;
      out_bank.sram_en[bank_sel] = ~fire;
      out_bank.wr[bank_sel]      = ~fire;
   end

   assign out_bank.addr = wr_addr;

endmodule

`default_nettype wire

/* verilog/stage_handshake.sv */
`default_nettype none

module stage_handshake
   import bank_if_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 image_done,
   input  logic [bank_w-1:0]    bank_sel,
   input  logic [num_banks-1:0] pre_sram_full,
   input  logic [num_banks-1:0] next_sram_empty,
   output logic [num_banks-1:0] img_request,
   output logic [num_banks-1:0] next_sram_full
);

   logic [num_banks-1:0] full_q;   // pre_sram_full one cycle back
   logic [num_banks-1:0] empty_q;  // next_sram_empty one cycle back
   logic [num_banks-1:0] full_rise;
   logic [num_banks-1:0] empty_rise;
   logic [num_banks-1:0] done_bank;

   // ******************************
   // edge detect per bank
   // ******************************
   assign full_rise  = pre_sram_full & ~full_q;
   assign empty_rise = next_sram_empty & ~empty_q;

   always_comb begin
      done_bank = '0;
      done_bank[bank_sel] = image_done;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         full_q         <= '0;
         empty_q        <= '0;
         img_request    <= '1;  // both input banks may be filled
         next_sram_full <= '0;
      end else begin
         full_q  <= pre_sram_full;
         empty_q <= next_sram_empty;

         for (int b = 0; b < num_banks; b++) begin
            if (empty_rise[b])
               next_sram_full[b] <= 1'b0;  // next stage drained it
            if (full_rise[b])
               img_request[b] <= 1'b0;     // previous stage loaded it

            // a finished image wins over a clear in the same cycle
            if (done_bank[b]) begin
               next_sram_full[b] <= 1'b1;
               img_request[b]    <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/conv_layer_ctrl.sv */
`default_nettype none

module conv_layer_ctrl
   import conv_geom_pkg::*;
   import bank_if_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic [data_w-1:0]      din,
   input  logic [num_banks-1:0]   pre_sram_full,
   input  logic [num_banks-1:0]   next_sram_empty,
   output logic [data_w-1:0]      dout,
   output in_bank_ctl_t           in_bank,
   output out_bank_ctl_t          out_bank,
   output wgt_ctl_t               wgt,
   output logic [num_engines-1:0] asm_send,
   output logic                   calculate_en,
   output logic [num_banks-1:0]   img_request,
   output logic [num_banks-1:0]   next_sram_full
);

   logic              step;
   logic              window_done;
   logic              last_step;
   logic              image_done;
   logic [bank_w-1:0] bank_sel;
   loop_pos_t         pos;

   // ******************************
   // loop control and weights
   // ******************************
   conv_sequencer u_seq (
      .clk             (clk),
      .rst             (rst),
      .pre_sram_full   (pre_sram_full),
      .next_sram_empty (next_sram_empty),
      .image_done      (image_done),
      .step            (step),
      .window_done     (window_done),
      .last_step       (last_step),
      .bank_sel        (bank_sel),
      .pos             (pos),
      .calculate_en    (calculate_en),
      .wgt             (wgt)
   );

   window_addr_gen u_win (
      .clk      (clk),
      .rst      (rst),
      .step     (step),
      .bank_sel (bank_sel),
      .pos      (pos),
      .din      (din),
      .in_bank  (in_bank),
      .dout     (dout)
   );

   result_writer u_wr (
      .clk         (clk),
      .rst         (rst),
      .step        (step),
      .window_done (window_done),
      .last_step   (last_step),
      .bank_sel    (bank_sel),
      .asm_send    (asm_send),
      .out_bank    (out_bank),
      .image_done  (image_done)
   );

   stage_handshake u_hs (
      .clk             (clk),
      .rst             (rst),
      .image_done      (image_done),
      .bank_sel        (bank_sel),
      .pre_sram_full   (pre_sram_full),
      .next_sram_empty (next_sram_empty),
      .img_request     (img_request),
      .next_sram_full  (next_sram_full)
   );

endmodule

`default_nettype wire

/* verification/tb_model.svh */
`ifndef tb_model_svh
`define tb_model_svh

// ******************************
// run constants
// ******************************
localparam logic [31:0] lfsr_seed = 32'd91065;
localparam int img_timeout   = 800000;  // cycles for one image with stalls
localparam int short_timeout = 50;

localparam int steps_per_win  = num_ch * num_taps;             // 27
localparam int steps_per_pix  = steps_per_win * num_groups;    // 432
localparam int steps_per_img  = steps_per_pix * img_pixels;
localparam int writes_per_img = img_pixels * num_groups;

logic [31:0]       lfsr_q;
logic [data_w-1:0] mem [img_pixels];  // input bank contents

// 32 bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v = {v[30:0], lfsr_q[0]};
   end
   return v;
endfunction

task automatic fill_mem();
   for (int a = 0; a < img_pixels; a++)
      mem[a] = data_w'(rand_bits(data_w));
endtask

// ******************************
// expected values per step index
// ******************************
function automatic int step_tap(input int s);
   return (s / num_ch) % num_taps;
endfunction

function automatic int step_group(input int s);
   return (s / steps_per_win) % num_groups;
endfunction

function automatic int exp_wgt_addr(input int s);
   return (s % num_ch) + num_ch * step_tap(s) + steps_per_win * step_group(s);
endfunction

function automatic int nb_row(input int s);
   return (s / steps_per_pix) / img_side + step_tap(s) / win_side - 1;
endfunction

function automatic int nb_col(input int s);
   return (s / steps_per_pix) % img_side + step_tap(s) % win_side - 1;
endfunction

function automatic logic tap_padded(input int s);
   return (nb_row(s) < 0) || (nb_row(s) >= img_side) ||
          (nb_col(s) < 0) || (nb_col(s) >= img_side);
endfunction

function automatic int tap_addr(input int s);
   return nb_row(s) * img_side + nb_col(s);
endfunction

task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
   if (got !== exp) begin
      $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1);
   end
endtask

`endif

/* verification/conv_layer_ctrl_tb.sv */
`default_nettype none

module conv_layer_ctrl_tb
   import conv_geom_pkg::*;
   import bank_if_pkg::*;
();

   logic                   clk;
   logic                   rst;
   logic [data_w-1:0]      din;
   logic [num_banks-1:0]   pre_sram_full;
   logic [num_banks-1:0]   next_sram_empty;
   logic [data_w-1:0]      dout;
   in_bank_ctl_t           in_bank;
   out_bank_ctl_t          out_bank;
   wgt_ctl_t               wgt;
   logic [num_engines-1:0] asm_send;
   logic                   calculate_en;
   logic [num_banks-1:0]   img_request;
   logic [num_banks-1:0]   next_sram_full;

   logic [num_banks-1:0] pre_lvl, emp_lvl;  // stage levels before stalls
   logic                 stall_on;
   int                   ab;                // active bank

   logic             running;     // first step of the image seen
   int               s_idx;       // steps done in this image
   int               post_cnt;    // cycles since the last step of the image
   int               wr_cnt;
   logic             final_seen;  // drain write after the last step
   logic             prev_step, prev_pad, rd_pending;
   int               prev_nb;
   logic [pix_w-1:0] last_addr;

   localparam int w_steps    = 0;
   localparam int w_write    = 1;
   localparam int w_full_set = 2;
   localparam int w_full_clr = 3;
   localparam int w_req_clr  = 4;

   `include "tb_model.svh"

   conv_layer_ctrl DUT (
      .clk             (clk),
      .rst             (rst),
      .din             (din),
      .pre_sram_full   (pre_sram_full),
      .next_sram_empty (next_sram_empty),
      .dout            (dout),
      .in_bank         (in_bank),
      .out_bank        (out_bank),
      .wgt             (wgt),
      .asm_send        (asm_send),
      .calculate_en    (calculate_en),
      .img_request     (img_request),
      .next_sram_full  (next_sram_full)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_cycle();
      logic                   lv_ok, exp_step, exp_fire;
      logic [num_banks-1:0]   act, exp_en, exp_oen;
      logic [num_engines-1:0] exp_wen, exp_send;
      logic [data_w-1:0]      exp_d;
      act   = num_banks'(1) << ab;
      lv_ok = pre_sram_full[ab] && next_sram_empty[ab];
      if (s_idx == steps_per_img)
         post_cnt++;
      if (!running && calculate_en) begin
         compare(lv_ok, 1, "stage levels at the first step");
         running = 1'b1;
      end
      exp_step = running && (s_idx < steps_per_img) && lv_ok;  // stalls hold everything
      compare(calculate_en, exp_step, "calculate_en");
      exp_en = exp_step ? ~act : '1;
      compare(in_bank.sram_en, exp_en, "input bank chip enables");
      compare(in_bank.rd, exp_en, "input bank read enables");
      exp_wen = {num_engines{~exp_step}};
      compare(wgt.sram_en, exp_wen, "weight chip enables");
      compare(wgt.rd, exp_wen, "weight read enables");
      if (exp_step)
         compare(wgt.addr, exp_wgt_addr(s_idx), "weight address");

      // ******************************
      // window data one cycle late
      // ******************************
      if (prev_step) begin
         exp_d = prev_pad ? '0 : mem[prev_nb];
         compare(dout, exp_d, "dout");
         if (!prev_pad)
            compare(in_bank.addr, prev_nb, "read address");
      end else begin
         compare(in_bank.addr, last_addr, "read address during a hold");
      end

      // each write trails its window-done step by two steps
      if (s_idx == steps_per_img)
         exp_fire = (post_cnt == 2);  // last write two cycles after the final step
      else
         exp_fire = exp_step && (s_idx >= steps_per_win) && (s_idx % steps_per_win == 1);
      exp_send = exp_fire ? '1 : '0;
      compare(asm_send, exp_send, "asm_send");
      exp_oen = exp_fire ? ~act : '1;
      compare(out_bank.sram_en, exp_oen, "output bank chip enables");
      compare(out_bank.wr, exp_oen, "output bank write strobes");
      if (exp_fire) begin
         compare(out_bank.addr, wr_cnt, "next_addr");
         wr_cnt++;
         if (s_idx == steps_per_img)
            final_seen = 1'b1;
      end

      rd_pending = !in_bank.rd[ab] && !in_bank.sram_en[ab];  // SRAM answers next cycle
      last_addr  = in_bank.addr;
      prev_step  = exp_step;
      if (exp_step) begin
         prev_pad = tap_padded(s_idx);
         prev_nb  = tap_addr(s_idx);
         s_idx++;
      end
   endtask

   task automatic tick();
      logic [num_banks-1:0] stall_p, stall_e;
      @(negedge clk);
      stall_p = '0;
      stall_e = '0;
      if (stall_on) begin
         stall_p[ab] = (rand_bits(4) == 0);  // about one cycle in 16
         stall_e[ab] = (rand_bits(4) == 0);
      end
      if (rd_pending)
         din = mem[in_bank.addr];
      pre_sram_full   = pre_lvl & ~stall_p;
      next_sram_empty = emp_lvl & ~stall_e;
      #1;
      check_cycle();
   endtask

   task automatic give_up(input string what);
      $display("timed out waiting for %s at time %0t", what, $time);
      $display("Some tests failed");
      $fatal(1);
   endtask

   function automatic logic watched(input int sel, input int b);
      case (sel)
         w_steps:    return s_idx == steps_per_img;
         w_write:    return final_seen;
         w_full_set: return next_sram_full[b];
         w_full_clr: return !next_sram_full[b];
         default:    return !img_request[b];
      endcase
   endfunction

   task automatic wait_for(input int sel, input int b, input int limit, input string what);
      int n;
      n = 0;
      while (!watched(sel, b)) begin
         if (n == limit)
            give_up(what);
         tick();
         n++;
      end
   endtask

   task automatic finish_image(input int b);
      wait_for(w_steps, b, img_timeout, "all steps of the image");
      stall_on = 1'b0;
      wait_for(w_write, b, short_timeout, "the last result write");
      compare(wr_cnt, writes_per_img, "writes in the image");
      wait_for(w_full_set, b, short_timeout, "next_sram_full after the image");
      compare(img_request[b], 1, "img_request after the image");
   endtask

   initial begin
      lfsr_q = lfsr_seed;
      fill_mem();
      rst = 1'b0;
      din = '0;
      pre_sram_full   = '0;
      next_sram_empty = '0;
      pre_lvl  = '0;
      emp_lvl  = '0;
      stall_on = 1'b0;
      ab       = 0;
      running  = 1'b0;
      s_idx    = 0;
      post_cnt = 0;
      wr_cnt   = 0;
      final_seen = 1'b0;
      prev_step  = 1'b0;
      prev_pad   = 1'b0;
      prev_nb    = 0;
      rd_pending = 1'b0;
      repeat (3) @(negedge clk);
      rst = 1'b1;
      #1;
      compare(in_bank.sram_en & in_bank.rd, 2'b11, "input enables after reset");
      compare(out_bank.sram_en & out_bank.wr, 2'b11, "output enables after reset");
      compare(wgt.sram_en & wgt.rd, 8'hff, "weight enables after reset");
      compare(calculate_en, 0, "calculate_en after reset");
      compare(asm_send, 0, "asm_send after reset");
      compare(img_request, 2'b11, "img_request after reset");
      compare(next_sram_full, 2'b00, "next_sram_full after reset");
      last_addr = in_bank.addr;

      // ******************************
      // first image, bank 1
      // ******************************
      pre_lvl  = 2'b01;
      emp_lvl  = 2'b01;
      stall_on = 1'b1;
      wait_for(w_req_clr, 0, short_timeout, "img_request[0] to clear");
      compare(img_request[1], 1, "img_request of the idle bank");
      finish_image(0);
      compare(next_sram_full[1], 0, "next_sram_full of the idle bank");

      // ******************************
      // second image, bank 2
      // ******************************
      ab = 1;
      running = 1'b0;
      s_idx = 0;
      post_cnt = 0;
      wr_cnt = 0;
      final_seen = 1'b0;
      pre_lvl  = 2'b10;  // bank 1 drops while bank 2 loads
      emp_lvl  = 2'b10;
      stall_on = 1'b1;
      wait_for(w_req_clr, 1, short_timeout, "img_request[1] to clear");
      compare(next_sram_full[0], 1, "next_sram_full[0] before its edge");
      emp_lvl[0] = 1'b1;
      wait_for(w_full_clr, 0, short_timeout, "next_sram_full[0] to clear");
      compare(img_request[0], 1, "img_request[0] before its edge");
      pre_lvl[0] = 1'b1;
      wait_for(w_req_clr, 0, short_timeout, "img_request[0] to clear again");
      pre_lvl[0] = 1'b0;  // keep bank 1 from starting a third image
      emp_lvl[0] = 1'b0;
      finish_image(1);

      emp_lvl[1] = 1'b0;
      tick();
      emp_lvl[1] = 1'b1;
      wait_for(w_full_clr, 1, short_timeout, "next_sram_full[1] to clear");
      compare(img_request[1], 1, "img_request[1] before its edge");
      pre_lvl[1] = 1'b0;
      tick();
      pre_lvl[1] = 1'b1;
      wait_for(w_req_clr, 1, short_timeout, "img_request[1] to clear again");

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verification
verilog/conv_geom_pkg.sv
verilog/bank_if_pkg.sv
verilog/conv_sequencer.sv
verilog/window_addr_gen.sv
verilog/result_writer.sv
verilog/stage_handshake.sv
verilog/conv_layer_ctrl.sv
verification/conv_layer_ctrl_tb.sv

/* Bender.yml */
package:
  name: conv_layer_ctrl

sources:
  - files:
      - verilog/conv_geom_pkg.sv
      - verilog/bank_if_pkg.sv
      - verilog/conv_sequencer.sv
      - verilog/window_addr_gen.sv
      - verilog/result_writer.sv
      - verilog/stage_handshake.sv
      - verilog/conv_layer_ctrl.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/conv_layer_ctrl_tb.sv
